//--- verilog.f
src/gru_pkg.sv
src/gru_operand_bank.sv
src/gru_weight_rom.sv
src/gru_mac.sv
src/gru_activation.sv
src/gru_sequencer.sv
src/gru_state_update.sv
src/gru_cell.sv
dv/gru_cell_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS ?= --binary --timing -j 0 -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall
TOP ?= gru_cell_tb
RTL_TOP ?= gru_cell
FILELIST ?= verilog.f
OBJ_DIR ?= obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TEST PASS"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- gru_weights.mem
// q8.8 words: 9 biases (gate z, r, h by neuron), then 9 rows of 6 weights (3 x, 3 h)
0040
ffc0
0020
0080
ffa0
0010
0000
0030
ffe0
0040
ffe0
0030
0020
fff0
0018
ffa0
0010
ffd0
0028
ffc8
0008
0050
0030
ffe8
ffd8
0044
0010
0038
ffc0
0060
0010
0020
ffe0
ffb0
ffe8
0018
ffd0
0008
ffc0
0024
0048
ffe4
0030
ffd4
0058
0070
ff90
0040
ffe0
0050
ffb8
ff88
0034
0064
ffcc
0028
0044
0058
ffa8
ff9c
0070
ffc4
0030

//--- dv/gru_cell_tb.sv
`timescale 1ns/1ps
`default_nettype none

module gru_cell_tb;
	import gru_pkg::*;

	localparam int STEP_TIMEOUT = 400;
	localparam int QUIET_CYCLES = 150;
	localparam int N_RANDOM = 40;
	localparam int N_CHAIN = 10;
	localparam int SPAN_2Q = 512;
	localparam int BIG_Q = 24576;

	logic clk;
	logic rst;
	logic start;
	vec_in_t x_in;
	vec_state_t h_in;
	vec_state_t h_out;
	logic valid;
	logic busy;

	logic signed [WORD_W-1:0] rom_model [ROM_DEPTH];
	int x_val [NB_INPUTS];
	int h_val [NB_NEURONS];
	int gated [NB_NEURONS];
	int exp_z [NB_NEURONS];
	int exp_h [NB_NEURONS];
	int n_checks;
	int n_errors;
	int n_timeouts;

	gru_cell dut0 (
		.clk(clk), .rst(rst), .start(start),
		.x_in(x_in), .h_in(h_in),
		.h_out(h_out), .valid(valid), .busy(busy)
	);

	always #2 clk = ~clk;

	//////////////////////////////
	// reference model

	function automatic int clamp(input int v, input int lo, input int hi);
		if (v > hi)
			return hi;
		if (v < lo)
			return lo;
		return v;
	endfunction

	function automatic int q_mul(input int a, input int b);
		return (a * b) >>> FRAC_W;
	endfunction

	function automatic int hard_sigmoid(input int s);
		return clamp((s >>> 2) + ONE_Q / 2, 0, ONE_Q);
	endfunction

	function automatic int hard_tanh(input int s);
		return clamp(s, -ONE_Q, ONE_Q);
	endfunction

	// bias plus one weight row, x columns first
	function automatic int dot_row(input int g, input int i, input bit use_gated);
		int s;
		int w;
		int op;
		s = int'(rom_model[BIAS_BASE + g * NB_NEURONS + i]);
		for (int k = 0; k < NB_COLS; k++) begin
			w = int'(rom_model[WEIGHT_BASE + (g * NB_NEURONS + i) * NB_COLS + k]);
			if (k < NB_INPUTS)
				op = x_val[k];
			else if (use_gated)
				op = gated[k - NB_INPUTS];
			else
				op = h_val[k - NB_INPUTS];
			s += q_mul(w, op);
		end
		return clamp(s, WORD_MIN, WORD_MAX);
	endfunction

	task automatic predict_step();
		int r [NB_NEURONS];
		int c;
		for (int i = 0; i < NB_NEURONS; i++) begin
			exp_z[i] = hard_sigmoid(dot_row(int'(gate_z), i, 1'b0));
			r[i] = hard_sigmoid(dot_row(int'(gate_r), i, 1'b0));
		end
		for (int j = 0; j < NB_NEURONS; j++)
			gated[j] = q_mul(r[j], h_val[j]);
		for (int i = 0; i < NB_NEURONS; i++) begin
			c = hard_tanh(dot_row(int'(gate_h), i, 1'b1));
			exp_h[i] = clamp((exp_z[i] * h_val[i] + (ONE_Q - exp_z[i]) * c) >>> FRAC_W,
				WORD_MIN, WORD_MAX);
		end
	endtask

	//////////////////////////////
	// stimulus and checks

	task automatic randomize_inputs(input int span);
		for (int k = 0; k < NB_INPUTS; k++)
			x_val[k] = int'($urandom % (2 * span + 1)) - span;
		for (int i = 0; i < NB_NEURONS; i++)
			h_val[i] = int'($urandom % (2 * span + 1)) - span;
	endtask

	task automatic drive_inputs();
		for (int k = 0; k < NB_INPUTS; k++)
			x_in[k] = word_t'(x_val[k]);
		for (int i = 0; i < NB_NEURONS; i++)
			h_in[i] = word_t'(h_val[i]);
	endtask

	task automatic pulse_start();
		@(posedge clk);
		#1;
		drive_inputs();
		start = 1'b1;
		@(posedge clk);
		#1;
		start = 1'b0;
	endtask

	task automatic wait_valid(output bit seen);
		int cycles;
		cycles = 0;
		seen = valid;
		while (!seen && cycles < STEP_TIMEOUT) begin
			@(posedge clk);
			#1;
			cycles++;
			seen = valid;
		end
		if (!seen) begin
			$display("timeout: no valid pulse within %0d cycles of start", STEP_TIMEOUT);
			n_timeouts++;
		end
	endtask

	task automatic check_h_out();
		for (int i = 0; i < NB_NEURONS; i++) begin
			n_checks++;
			if (h_out[i] !== word_t'(exp_h[i])) begin
				$display("** Error: h_out[%0d] = %h, expected %h", i, h_out[i],
					word_t'(exp_h[i]));
				n_errors++;
			end
		end
	endtask

	task automatic check_busy_high();
		n_checks++;
		if (busy !== 1'b1) begin
			$display("** Error: busy = %h, expected %h", busy, 1'b1);
			n_errors++;
		end
	endtask

	task automatic check_idle();
		n_checks++;
		if (valid !== 1'b0 || busy !== 1'b0) begin
			$display("** Error: valid/busy = %h/%h, expected %h/%h", valid, busy, 1'b0, 1'b0);
			n_errors++;
		end
		n_checks++;
		if (h_out !== '0) begin
			$display("** Error: h_out = %h, expected %h", h_out, vec_state_t'(0));
			n_errors++;
		end
	endtask

	// z lives inside the state update block
	task automatic check_z_saturated();
		word_t z_dut;
		for (int i = 0; i < NB_NEURONS; i++) begin
			z_dut = dut0.upd0.z_mem[i];
			n_checks++;
			if (z_dut !== word_t'(0) && z_dut !== word_t'(ONE_Q)) begin
				$display("** Error: z_mem[%0d] = %h, expected %h or %h", i, z_dut,
					word_t'(0), word_t'(ONE_Q));
				n_errors++;
			end
			n_checks++;
			if (z_dut !== word_t'(exp_z[i])) begin
				$display("** Error: z_mem[%0d] = %h, expected %h", i, z_dut,
					word_t'(exp_z[i]));
				n_errors++;
			end
		end
	endtask

	task automatic run_step();
		bit seen;
		predict_step();
		pulse_start();
		check_busy_high();
		wait_valid(seen);
		if (seen)
			check_h_out();
	endtask

	// start pulsed mid-step must be dropped
	task automatic run_ignored_start();
		bit seen;
		int extra;
		randomize_inputs(SPAN_2Q);
		predict_step();
		pulse_start();
		repeat (5) @(posedge clk);
		#1;
		check_busy_high();
		randomize_inputs(SPAN_2Q);
		drive_inputs();
		start = 1'b1;
		@(posedge clk);
		#1;
		start = 1'b0;
		wait_valid(seen);
		if (seen)
			check_h_out();
		extra = 0;
		for (int n = 0; n < QUIET_CYCLES; n++) begin
			@(posedge clk);
			#1;
			if (valid)
				extra++;
		end
		n_checks++;
		if (extra != 0) begin
			$display("a start pulsed while busy produced %0d extra valid pulses", extra);
			n_errors++;
		end
	endtask

	initial begin
		$readmemh("gru_weights.mem", rom_model);
		void'($urandom(32'hd740));
		clk = 1'b0;
		rst = 1'b1;
		start = 1'b0;
		x_in = '0;
		h_in = '0;
		n_checks = 0;
		n_errors = 0;
		n_timeouts = 0;
		repeat (16) @(posedge clk);
		#1;
		rst = 1'b0;

		repeat (3) begin
			@(posedge clk);
			#1;
			check_idle();
		end

		for (int n = 0; n < N_RANDOM; n++) begin
			randomize_inputs(SPAN_2Q);
			run_step();
		end

		// gates pinned at both rails
		for (int k = 0; k < NB_INPUTS; k++)
			x_val[k] = BIG_Q;
		for (int i = 0; i < NB_NEURONS; i++)
			h_val[i] = BIG_Q;
		run_step();
		check_z_saturated();
		for (int k = 0; k < NB_INPUTS; k++)
			x_val[k] = -BIG_Q;
		for (int i = 0; i < NB_NEURONS; i++)
			h_val[i] = -BIG_Q;
		run_step();
		check_z_saturated();

		run_ignored_start();

		randomize_inputs(SPAN_2Q);
		for (int n = 0; n < N_CHAIN; n++) begin
			run_step();
			randomize_inputs(SPAN_2Q);
			for (int i = 0; i < NB_NEURONS; i++)
				h_val[i] = exp_h[i];
		end

		$display("checks %0d, errors %0d, timeouts %0d", n_checks, n_errors, n_timeouts);
		if (n_errors == 0 && n_timeouts == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- src/gru_cell.sv
`timescale 1ns/1ps
`default_nettype none

module gru_cell (
	input wire logic clk,
	input wire logic rst,
	input wire logic start,
	input wire gru_pkg::vec_in_t x_in,
	input wire gru_pkg::vec_state_t h_in,
	output gru_pkg::vec_state_t h_out,
	output logic valid,
	output logic busy
);
	import gru_pkg::*;

	logic start_acc;
	logic [ROM_ADDR_W-1:0] addr;
	word_t rom_data;
	logic [COL_W-1:0] idx;
	logic op_sel;
	word_t operand;
	word_t h_word;
	logic acc_load;
	logic acc_en;
	logic acc_done;
	word_t sum;
	gate_e gate;
	word_t act;
	logic r_we;
	logic z_we;
	logic blend_en;
	logic step_done;
	logic [NRN_W-1:0] neuron;

	// start is dropped while a step runs
	assign start_acc = start && !busy;

	//////////////////////////////
	// input side

	gru_operand_bank bank0 (
		.clk(clk), .rst(rst), .start(start_acc),
		.x_in(x_in), .h_in(h_in),
		.idx(idx), .op_sel(op_sel),
		.r_we(r_we), .r_idx(neuron), .r_val(act),
		.operand(operand), .h_word(h_word)
	);

	gru_weight_rom rom0 (.clk(clk), .addr(addr), .data(rom_data));

	//////////////////////////////
	// processing

	gru_sequencer seq0 (
		.clk(clk), .rst(rst), .start(start), .busy(busy),
		.addr(addr), .idx(idx), .op_sel(op_sel),
		.acc_load(acc_load), .acc_en(acc_en), .acc_done(acc_done),
		.gate(gate), .r_we(r_we), .z_we(z_we), .neuron(neuron),
		.blend_en(blend_en), .step_done(step_done)
	);

	gru_mac mac0 (
		.clk(clk), .rst(rst),
		.acc_load(acc_load), .acc_en(acc_en), .acc_done(acc_done),
		.coeff(rom_data), .operand(operand), .sum(sum)
	);

	gru_activation act0 (.gate(gate), .sum(sum), .act(act));

	//////////////////////////////
	// output side

	gru_state_update upd0 (
		.clk(clk), .rst(rst), .start(start_acc),
		.z_we(z_we), .blend_en(blend_en), .neuron(neuron),
		.act(act), .h_word(h_word), .step_done(step_done),
		.h_out(h_out), .valid(valid)
	);

endmodule

`default_nettype wire

//--- src/gru_state_update.sv
`timescale 1ns/1ps
`default_nettype none

module gru_state_update (
	input wire logic clk,
	input wire logic rst,
	input wire logic start,
	input wire logic z_we,
	input wire logic blend_en,
	input wire logic [gru_pkg::NRN_W-1:0] neuron,
	input wire gru_pkg::word_t act,
	input wire gru_pkg::word_t h_word,
	input wire logic step_done,
	output gru_pkg::vec_state_t h_out,
	output logic valid
);
	import gru_pkg::*;

	word_t z_mem [NB_NEURONS];
	vec_state_t h_next;
	word_t z_cur;
	acc_t keep_term;
	acc_t cand_term;
	acc_t blend;

	// z*h + (1-z)*c for the current neuron
	always_comb begin
		z_cur = z_mem[neuron];
		keep_term = acc_t'(z_cur) * acc_t'(h_word);
		cand_term = (acc_t'(ONE_Q) - acc_t'(z_cur)) * acc_t'(act);
		blend = (keep_term + cand_term) >>> FRAC_W;
	end

	always_ff @(posedge clk) begin
		if (z_we) begin
			z_mem[neuron] <= act;
		end
		if (start)
			h_next <= '0;
		else if (blend_en)
			h_next[neuron] <= sat_word(blend);
	end

	// h_out only moves when a whole step is done
	always_ff @(posedge clk) begin
		if (rst) begin
			h_out <= '0;
			valid <= 1'b0;
		end else begin
			valid <= step_done;
			if (step_done)
				h_out <= h_next;
		end
	end

endmodule

`default_nettype wire

//--- src/gru_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module gru_sequencer (
	input wire logic clk,
	input wire logic rst,
	input wire logic start,
	output logic busy,
	output logic [gru_pkg::ROM_ADDR_W-1:0] addr,
	output logic [gru_pkg::COL_W-1:0] idx,
	output logic op_sel,
	output logic acc_load,
	output logic acc_en,
	output logic acc_done,
	output gru_pkg::gate_e gate,
	output logic r_we,
	output logic z_we,
	output logic [gru_pkg::NRN_W-1:0] neuron,
	output logic blend_en,
	output logic step_done
);
	import gru_pkg::*;

	seq_state_e state;
	gate_e cur_gate;
	logic [NRN_W-1:0] cur_neuron;
	logic [COL_W-1:0] col;
	logic last_neuron;
	logic last_col;
	int row;

	assign last_neuron = (cur_neuron == NRN_W'(NB_NEURONS - 1));
	assign last_col = (col == COL_W'(NB_COLS - 1));
	// candidate pass reads the gated state
	assign op_sel = (cur_gate == gate_h);

	//////////////////////////////
	// rom address and operand index

	always_comb begin
		row = int'(cur_gate) * NB_NEURONS + int'(cur_neuron);
		idx = '0;
		addr = '0;
		if (state == st_bias) begin
			addr = ROM_ADDR_W'(BIAS_BASE + row);
		end else if (state == st_mac) begin
			idx = col;
			addr = ROM_ADDR_W'(WEIGHT_BASE + row * NB_COLS + int'(col));
		end
	end

	//////////////////////////////
	// pass, neuron and column walk

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= st_idle;
			cur_gate <= gate_z;
			cur_neuron <= '0;
			col <= '0;
		end else begin
			case (state)
				st_idle: begin
					if (start && !busy) begin
						cur_gate <= gate_z;
						cur_neuron <= '0;
						state <= st_bias;
					end
				end
				st_bias: begin
					col <= '0;
					state <= st_mac;
				end
				st_mac: begin
					col <= col + 1'b1;
					if (last_col)
						state <= st_finish;
				end
				st_finish: begin
					state <= st_bias;
					if (cur_gate == gate_z) begin
						cur_gate <= gate_r;
					end else if (cur_gate == gate_r) begin
						// z then r per neuron, candidates after the last one
						if (last_neuron) begin
							cur_gate <= gate_h;
							cur_neuron <= '0;
						end else begin
							cur_gate <= gate_z;
							cur_neuron <= cur_neuron + 1'b1;
						end
					end else if (last_neuron) begin
						state <= st_done;
					end else begin
						cur_neuron <= cur_neuron + 1'b1;
					end
				end
				st_done: state <= st_idle;
				default: state <= st_idle;
			endcase
		end
	end

	// strobes trail the address by one cycle, matching rom and bank
	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
			acc_load <= 1'b0;
			acc_en <= 1'b0;
			acc_done <= 1'b0;
			z_we <= 1'b0;
			r_we <= 1'b0;
			blend_en <= 1'b0;
			step_done <= 1'b0;
			gate <= gate_z;
			neuron <= '0;
		end else begin
			acc_load <= (state == st_bias);
			acc_en <= (state == st_mac);
			acc_done <= (state == st_mac) && last_col;
			z_we <= (state == st_finish) && (cur_gate == gate_z);
			r_we <= (state == st_finish) && (cur_gate == gate_r);
			blend_en <= (state == st_finish) && (cur_gate == gate_h);
			step_done <= (state == st_done);
			if (state == st_finish) begin
				gate <= cur_gate;
				neuron <= cur_neuron;
			end
			if (state == st_idle && start && !busy)
				busy <= 1'b1;
			else if (step_done)
				busy <= 1'b0;
		end
	end

	a_neuron_range: assert property (@(posedge clk) disable iff (rst)
		busy |-> (cur_neuron < NB_NEURONS) && (neuron < NB_NEURONS))
		else $error("neuron index out of range");

endmodule

`default_nettype wire

//--- src/gru_activation.sv
`timescale 1ns/1ps
`default_nettype none

module gru_activation (
	input wire gru_pkg::gate_e gate,
	input wire gru_pkg::word_t sum,
	output gru_pkg::word_t act
);
	import gru_pkg::*;

	acc_t sig_lin;

	always_comb begin
		sig_lin = (acc_t'(sum) >>> 2) + acc_t'(ONE_Q / 2);
		if (gate == gate_h) begin
			// hard tanh
			if (acc_t'(sum) > acc_t'(ONE_Q))
				act = word_t'(ONE_Q);
			else if (acc_t'(sum) < acc_t'(-ONE_Q))
				act = word_t'(-ONE_Q);
			else
				act = sum;
		end else begin
			// hard sigmoid for z and r
			if (sig_lin > acc_t'(ONE_Q))
				act = word_t'(ONE_Q);
			else if (sig_lin < 0)
				act = '0;
			else
				act = word_t'(sig_lin);
		end
	end

endmodule

`default_nettype wire

//--- src/gru_mac.sv
`timescale 1ns/1ps
`default_nettype none

module gru_mac (
	input wire logic clk,
	input wire logic rst,
	input wire logic acc_load,
	input wire logic acc_en,
	input wire logic acc_done,
	input wire gru_pkg::word_t coeff,
	input wire gru_pkg::word_t operand,
	output gru_pkg::word_t sum
);
	import gru_pkg::*;

	acc_t product;
	acc_t acc;
	acc_t acc_next;

	// q8.8 times q8.8, back to q.8
	always_comb begin
		product = (acc_t'(coeff) * acc_t'(operand)) >>> FRAC_W;
		acc_next = acc + product;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			acc <= '0;
			sum <= '0;
		end else begin
			if (acc_load)
				acc <= acc_t'(coeff);
			else if (acc_en)
				acc <= acc_next;
			// last product may land in the done cycle
			if (acc_done)
				sum <= sat_word(acc_en ? acc_next : acc);
		end
	end

	// bias load and product add come from different sequencer states
	a_load_en_excl: assert property (@(posedge clk) disable iff (rst)
		!(acc_load && acc_en))
		else $error("acc_load and acc_en high together");

endmodule

`default_nettype wire

//--- src/gru_weight_rom.sv
`timescale 1ns/1ps
`default_nettype none

module gru_weight_rom (
	input wire logic clk,
	input wire logic [gru_pkg::ROM_ADDR_W-1:0] addr,
	output gru_pkg::word_t data
);
	import gru_pkg::*;

	word_t mem [ROM_DEPTH];

	// biases at 0, weight rows from WEIGHT_BASE
	initial begin
		$readmemh("gru_weights.mem", mem);
	end

	always_ff @(posedge clk) begin
		data <= mem[addr];
	end

endmodule

`default_nettype wire

//--- src/gru_operand_bank.sv
`timescale 1ns/1ps
`default_nettype none

module gru_operand_bank (
	input wire logic clk,
	input wire logic rst,
	input wire logic start,
	input wire gru_pkg::vec_in_t x_in,
	input wire gru_pkg::vec_state_t h_in,
	input wire logic [gru_pkg::COL_W-1:0] idx,
	input wire logic op_sel,
	input wire logic r_we,
	input wire logic [gru_pkg::NRN_W-1:0] r_idx,
	input wire gru_pkg::word_t r_val,
	output gru_pkg::word_t operand,
	output gru_pkg::word_t h_word
);
	import gru_pkg::*;

	vec_in_t x_q;
	vec_state_t h_q;
	vec_state_t r_q;
	logic [COL_W-1:0] st_idx;
	word_t r_j;
	word_t h_j;
	acc_t gated;
	word_t op_next;

	always_ff @(posedge clk) begin
		if (start) begin
			x_q <= x_in;
			h_q <= h_in;
		end
		if (r_we) begin
			r_q[r_idx] <= r_val;
		end
	end

	// columns past the inputs address the state side
	always_comb begin
		st_idx = idx - COL_W'(NB_INPUTS);
		r_j = r_q[st_idx];
		h_j = h_q[st_idx];
		gated = (acc_t'(r_j) * acc_t'(h_j)) >>> FRAC_W;
		if (idx < COL_W'(NB_INPUTS))
			op_next = x_q[idx];
		else if (op_sel)
			op_next = word_t'(gated);
		else
			op_next = h_j;
	end

	// lines up with the registered rom word
	always_ff @(posedge clk) begin
		if (rst)
			operand <= '0;
		else
			operand <= op_next;
	end

	assign h_word = h_q[r_idx];

endmodule

`default_nettype wire

//--- src/gru_pkg.sv
`default_nettype none

package gru_pkg;

	// sizes
	localparam int NB_INPUTS = 3;
	localparam int NB_NEURONS = 3;
	localparam int NB_COLS = NB_INPUTS + NB_NEURONS;
	localparam int COL_W = $clog2(NB_COLS);
	localparam int NRN_W = $clog2(NB_NEURONS + 1);

	// q8.8 data path
	localparam int WORD_W = 16;
	localparam int FRAC_W = 8;
	localparam int ONE_Q = 256;
	localparam int ACC_W = 32;
	localparam int WORD_MAX = 2 ** (WORD_W - 1) - 1;
	localparam int WORD_MIN = -(2 ** (WORD_W - 1));

	// rom layout, biases first then weight rows
	localparam int ROM_DEPTH = 3 * NB_NEURONS + 3 * NB_NEURONS * NB_COLS;
	localparam int BIAS_BASE = 0;
	localparam int WEIGHT_BASE = 3 * NB_NEURONS;
	localparam int ROM_ADDR_W = $clog2(ROM_DEPTH);

	typedef logic signed [WORD_W-1:0] word_t;
	typedef logic signed [ACC_W-1:0] acc_t;
	typedef word_t [NB_INPUTS-1:0] vec_in_t;
	typedef word_t [NB_NEURONS-1:0] vec_state_t;

	typedef enum logic [1:0] {
		gate_z = 2'd0,
		gate_r = 2'd1,
		gate_h = 2'd2
	} gate_e;

	typedef enum logic [2:0] {
		st_idle,
		st_bias,
		st_mac,
		st_finish,
		st_done
	} seq_state_e;

	function automatic word_t sat_word(input acc_t v);
		if (v > acc_t'(WORD_MAX))
			return word_t'(WORD_MAX);
		if (v < acc_t'(WORD_MIN))
			return word_t'(WORD_MIN);
		return word_t'(v);
	endfunction

endpackage

`default_nettype wire
